// File: common/zbus_defs.svh
// z80 bus slave sizes, port base and memory window
`ifndef ZBUS_DEFS_SVH
`define ZBUS_DEFS_SVH

// high five bits of the i/o address low byte, ports 0xA0..0xA7
`define ZB_PORT_BASE 5'h14

// address bits 15..8 that select the ram window
`define ZB_MEM_WIN 8'hC0

// page width, 4 pages of 256 bytes
`define ZB_PAGE_BITS 2

// internal ram depth in bytes
`define ZB_RAM_DEPTH 1024

// opcode fetch counter width, wraps
`define ZB_CNT_W 8

// interrupt vector after reset
`define ZB_VECTOR_RST 8'hFF

`endif

// File: common/zbus_pkg.sv
// z80 bus slave types shared by decode, port block, data return and bus interface
`default_nettype none

package zbus_pkg;

	// kind of bus cycle currently on the z80 control lines
	typedef enum logic [2:0] {
		ZC_IDLE   = 3'd0,
		ZC_IORD   = 3'd1,
		ZC_IOWR   = 3'd2,
		ZC_MEMRD  = 3'd3,
		ZC_MEMWR  = 3'd4,
		ZC_FETCH  = 3'd5,
		ZC_INTACK = 3'd6
	} zcycle_t;

	// port index within the i/o block
	// 0..4 are plain read/write registers
	typedef enum logic [2:0] {
		ZP_GP0      = 3'd0,
		ZP_GP1      = 3'd1,
		ZP_GP2      = 3'd2,
		ZP_GP3      = 3'd3,
		ZP_GP4      = 3'd4,
		ZP_FETCHCNT = 3'd5,
		ZP_VECTOR   = 3'd6,
		ZP_PAGE     = 3'd7
	} zport_t;

endpackage

`default_nettype wire

// File: common/zbus_if.sv
// decoded z80 control levels and one-clock request strobes
`timescale 1ns/1ps
`default_nettype none

interface zdec_if;

	import zbus_pkg::*;

	// levels, active high
	logic rd;
	logic wr;
	logic m1;
	logic rst;

	// cycle kind, from levels only
	zcycle_t cycle;

	// single clk pulses, one per request
	logic iord_s;
	logic iowr_s;
	logic memrd_s;
	logic memwr_s;
	logic opfetch_s;

	modport src (
		output rd, wr, m1, rst,
		output cycle,
		output iord_s, iowr_s, memrd_s, memwr_s, opfetch_s
	);

	// port and ram blocks
	modport exec (
		input rd, wr, m1, rst,
		input iord_s, iowr_s, memrd_s, memwr_s, opfetch_s
	);

	// data return only looks at the cycle kind
	modport res (
		input cycle,
		input rd
	);

endinterface

`default_nettype wire

// File: hdl/zbus_decode.sv
// z80 control line decoder, makes levels, cycle kind and zpos-sampled strobes
`timescale 1ns/1ps
`default_nettype none

module zbus_decode (
	input logic clk,
	input logic reset,
	input logic zpos,
	input logic iorq_n,
	input logic mreq_n,
	input logic m1_n,
	input logic rfsh_n,
	input logic rd_n,
	input logic wr_n,
	zdec_if.src bus
);

	import zbus_pkg::*;

	logic iorq;
	logic mreq;
	logic intack;
	logic [1:0] iorq_r;
	logic [1:0] mreq_r;
	logic iorq_s;
	logic mreq_s;

	// plain inversions
	assign bus.rst = reset;
	assign bus.rd = !rd_n;
	assign bus.wr = !wr_n;
	assign bus.m1 = !m1_n;

	// m1 masks the i/o request so int ack never decodes a port
	assign iorq = !iorq_n && m1_n;
	// refresh cycles are not memory accesses
	assign mreq = !mreq_n && rfsh_n;
	assign intack = !iorq_n && bus.m1;

	always_comb
	begin
		if (intack)
			bus.cycle = ZC_INTACK;
		else if (iorq && bus.rd)
			bus.cycle = ZC_IORD;
		else if (iorq && bus.wr)
			bus.cycle = ZC_IOWR;
		else if (mreq && bus.rd && bus.m1)
			bus.cycle = ZC_FETCH;
		else if (mreq && bus.rd)
			bus.cycle = ZC_MEMRD;
		else if (mreq && bus.wr)
			bus.cycle = ZC_MEMWR;
		else
			bus.cycle = ZC_IDLE;
	end

	// stage 0 samples on zpos only, stage 1 follows every clk
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			iorq_r <= 2'b00;
			mreq_r <= 2'b00;
		end
		else
		begin
			if (zpos)
			begin
				iorq_r[0] <= iorq;
				mreq_r[0] <= mreq;
			end
			iorq_r[1] <= iorq_r[0];
			mreq_r[1] <= mreq_r[0];
		end
	end

	// rising edge of the sampled request, still present on the lines
	assign iorq_s = iorq_r[0] && !iorq_r[1] && iorq;
	assign mreq_s = mreq_r[0] && !mreq_r[1] && mreq;

	assign bus.iord_s = iorq_s && bus.rd;
	assign bus.iowr_s = iorq_s && bus.wr;
	assign bus.memrd_s = mreq_s && bus.rd;
	// wr comes late on a real z80 memory write, so go by !rd
	assign bus.memwr_s = mreq_s && !bus.rd;
	assign bus.opfetch_s = bus.memrd_s && bus.m1;

endmodule

`default_nettype wire

// File: hdl/zport_exec.sv
// i/o port register file with opcode fetch counter, interrupt vector and ram page
`timescale 1ns/1ps
`default_nettype none

`include "zbus_defs.svh"

module zport_exec (
	input logic clk,
	input logic [7:0] addr,
	input logic [7:0] din,
	zdec_if.exec bus,
	output logic hit,
	output logic [7:0] rdata,
	output logic [`ZB_PAGE_BITS-1:0] page,
	output logic [7:0] vector
);

	import zbus_pkg::*;

	zport_t idx;
	logic [7:0] regs [0:7];
	logic [`ZB_CNT_W-1:0] fetch_cnt;

	// address only, the cycle kind is checked in the data return block
	assign hit = (addr[7:3] == `ZB_PORT_BASE);
	assign idx = zport_t'(addr[2:0]);

	always_ff @(posedge clk)
	begin
		if (bus.rst)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= 8'h00;
			regs[ZP_VECTOR] <= `ZB_VECTOR_RST;
		end
		else if (bus.iowr_s && hit && idx != ZP_FETCHCNT)
		begin
			regs[idx] <= din;
		end
	end

	// one count per opcode fetch strobe
	always_ff @(posedge clk)
	begin
		if (bus.rst)
			fetch_cnt <= '0;
		else if (bus.opfetch_s)
			fetch_cnt <= fetch_cnt + 1'b1;
	end

	always_comb
	begin
		if (idx == ZP_FETCHCNT)
			rdata = 8'(fetch_cnt);
		else
			rdata = regs[idx];
	end

	assign page = regs[ZP_PAGE][`ZB_PAGE_BITS-1:0];
	assign vector = regs[ZP_VECTOR];

endmodule

`default_nettype wire

// File: hdl/zmem_exec.sv
// paged 1 KiB ram window in the z80 memory map
`timescale 1ns/1ps
`default_nettype none

`include "zbus_defs.svh"

module zmem_exec (
	input logic clk,
	input logic [15:0] addr,
	input logic [7:0] din,
	input logic [`ZB_PAGE_BITS-1:0] page,
	zdec_if.exec bus,
	output logic hit,
	output logic [7:0] rdata
);

	logic [7:0] ram [0:`ZB_RAM_DEPTH-1];
	logic [`ZB_PAGE_BITS+7:0] ram_idx;

	// 256 byte window, page picks the bank
	assign hit = (addr[15:8] == `ZB_MEM_WIN);
	assign ram_idx = {page, addr[7:0]};

	always_ff @(posedge clk)
	begin
		if (bus.memwr_s && hit)
			ram[ram_idx] <= din;
	end

	// async read, covers memory reads and opcode fetches
	always_comb
	begin
		if (bus.rd)
			rdata = ram[ram_idx];
		else
			rdata = 8'h00;
	end

endmodule

`default_nettype wire

// File: hdl/zdata_result.sv
// read data source select and output enable for the z80 data bus
`timescale 1ns/1ps
`default_nettype none

module zdata_result (
	zdec_if.res bus,
	input logic port_hit,
	input logic [7:0] port_rdata,
	input logic mem_hit,
	input logic [7:0] mem_rdata,
	input logic [7:0] vector,
	output logic [7:0] dout,
	output logic dout_oe
);

	import zbus_pkg::*;

	always_comb
	begin
		dout = 8'h00;
		dout_oe = 1'b0;
		case (bus.cycle)
			ZC_IORD:
			begin
				if (bus.rd && port_hit)
				begin
					dout = port_rdata;
					dout_oe = 1'b1;
				end
			end
			ZC_MEMRD, ZC_FETCH:
			begin
				if (bus.rd && mem_hit)
				begin
					dout = mem_rdata;
					dout_oe = 1'b1;
				end
			end
			// vector goes out on every int ack, no rd on this cycle
			ZC_INTACK:
			begin
				dout = vector;
				dout_oe = 1'b1;
			end
			default:
			begin
				dout = 8'h00;
				dout_oe = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/zbus_top.sv
// z80 bus slave top, decode feeding port and ram blocks and the data return
`timescale 1ns/1ps
`default_nettype none

`include "zbus_defs.svh"

module zbus_top (
	input logic clk,
	input logic reset,
	input logic zpos,
	input logic iorq_n,
	input logic mreq_n,
	input logic m1_n,
	input logic rfsh_n,
	input logic rd_n,
	input logic wr_n,
	input logic [15:0] addr,
	input logic [7:0] din,
	output logic [7:0] dout,
	output logic dout_oe
);

	logic port_hit;
	logic [7:0] port_rdata;
	logic mem_hit;
	logic [7:0] mem_rdata;
	logic [`ZB_PAGE_BITS-1:0] page;
	logic [7:0] vector;

	zdec_if zdec ();

	zbus_decode decode0 (
		.clk(clk),
		.reset(reset),
		.zpos(zpos),
		.iorq_n(iorq_n),
		.mreq_n(mreq_n),
		.m1_n(m1_n),
		.rfsh_n(rfsh_n),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.bus(zdec.src)
	);

	// i/o ports only see the low address byte
	zport_exec port0 (
		.clk(clk),
		.addr(addr[7:0]),
		.din(din),
		.bus(zdec.exec),
		.hit(port_hit),
		.rdata(port_rdata),
		.page(page),
		.vector(vector)
	);

	zmem_exec mem0 (
		.clk(clk),
		.addr(addr),
		.din(din),
		.page(page),
		.bus(zdec.exec),
		.hit(mem_hit),
		.rdata(mem_rdata)
	);

	zdata_result result0 (
		.bus(zdec.res),
		.port_hit(port_hit),
		.port_rdata(port_rdata),
		.mem_hit(mem_hit),
		.mem_rdata(mem_rdata),
		.vector(vector),
		.dout(dout),
		.dout_oe(dout_oe)
	);

endmodule

`default_nettype wire

// File: verif/zbus_assertions.sv
// protocol checks on the decoder strobes, bound into zbus_decode
`timescale 1ns/1ps
`default_nettype none

module zbus_assertions (
	input logic clk,
	input logic reset,
	input logic m1_n,
	input logic rfsh_n,
	input logic iord_s,
	input logic iowr_s,
	input logic memrd_s,
	input logic memwr_s,
	input logic opfetch_s
);

	int fail_count = 0;

	// every strobe is a single clk pulse
	iord_width: assert property (@(posedge clk) disable iff (reset) iord_s |=> !iord_s)
		else
		begin
			$error("iord_s held longer than one clk");
			fail_count++;
		end

	iowr_width: assert property (@(posedge clk) disable iff (reset) iowr_s |=> !iowr_s)
		else
		begin
			$error("iowr_s held longer than one clk");
			fail_count++;
		end

	memrd_width: assert property (@(posedge clk) disable iff (reset) memrd_s |=> !memrd_s)
		else
		begin
			$error("memrd_s held longer than one clk");
			fail_count++;
		end

	memwr_width: assert property (@(posedge clk) disable iff (reset) memwr_s |=> !memwr_s)
		else
		begin
			$error("memwr_s held longer than one clk");
			fail_count++;
		end

	fetch_width: assert property (@(posedge clk) disable iff (reset) opfetch_s |=> !opfetch_s)
		else
		begin
			$error("opfetch_s held longer than one clk");
			fail_count++;
		end

	// refresh is never a memory access
	no_mem_in_rfsh: assert property (@(posedge clk) disable iff (reset)
		!rfsh_n |-> !(memrd_s || memwr_s || opfetch_s))
		else
		begin
			$error("memory strobe during refresh");
			fail_count++;
		end

	// int ack must not look like a port access
	no_io_in_m1: assert property (@(posedge clk) disable iff (reset)
		!m1_n |-> !(iord_s || iowr_s))
		else
		begin
			$error("i/o strobe while m1_n low");
			fail_count++;
		end

endmodule

bind zbus_decode zbus_assertions chk0 (
	.clk(clk),
	.reset(reset),
	.m1_n(m1_n),
	.rfsh_n(rfsh_n),
	.iord_s(bus.iord_s),
	.iowr_s(bus.iowr_s),
	.memrd_s(bus.memrd_s),
	.memwr_s(bus.memwr_s),
	.opfetch_s(bus.opfetch_s)
);

`default_nettype wire

// File: verif/zbus_tb.sv
// testbench for the z80 bus slave, bus cycle tasks checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module zbus_tb;

	localparam int CLK_NS = 20;
	// about 310 bus cycles of nine clks each, plus reset and margin
	localparam int N_CYCLES = 320;
	localparam int CYCLE_CLKS = 9;
	localparam int TIMEOUT_NS = (5 + N_CYCLES * CYCLE_CLKS + 100) * CLK_NS;
	localparam int N_FETCH = 258;

	logic clk;
	logic reset;
	logic zpos;
	logic iorq_n;
	logic mreq_n;
	logic m1_n;
	logic rfsh_n;
	logic rd_n;
	logic wr_n;
	logic [15:0] addr;
	logic [7:0] din;
	logic [7:0] dout;
	logic dout_oe;

	// reference model state
	logic [7:0] ports [0:7];
	logic [7:0] ram [0:1023];
	logic [7:0] fetch_cnt;
	logic [31:0] rng;

	// sampled in the middle of a cycle
	logic [7:0] rd_data;
	logic rd_oe;

	zbus_top dut0 (
		.clk(clk),
		.reset(reset),
		.zpos(zpos),
		.iorq_n(iorq_n),
		.mreq_n(mreq_n),
		.m1_n(m1_n),
		.rfsh_n(rfsh_n),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.addr(addr),
		.din(din),
		.dout(dout),
		.dout_oe(dout_oe)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = !clk;
	end

	// phase enable, high on every second clk
	always @(posedge clk)
		zpos <= !zpos;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		rng = xorshift32(rng);
		b = rng[7:0];
	endtask

	// arguments are active high, the bus lines active low
	task automatic run_cycle(input logic io, input logic mr, input logic m1, input logic rf,
		input logic rd, input logic wr, input logic [15:0] a, input logic [7:0] d);
		@(posedge clk);
		iorq_n <= !io;
		mreq_n <= !mr;
		m1_n <= !m1;
		rfsh_n <= !rf;
		rd_n <= !rd;
		wr_n <= !wr;
		addr <= a;
		din <= d;
		// six clk periods per z80 cycle
		repeat (5) @(posedge clk);
		@(negedge clk);
		rd_data = dout;
		rd_oe = dout_oe;
		@(posedge clk);
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		m1_n <= 1'b1;
		rfsh_n <= 1'b1;
		rd_n <= 1'b1;
		wr_n <= 1'b1;
		repeat (2) @(posedge clk);
	endtask

	task automatic check_read(input string what, input logic [7:0] exp, input logic exp_oe);
		logic [7:0] want;
		want = exp_oe ? exp : 8'h00;
		assert (rd_oe === exp_oe && rd_data === want)
		else
			fail_now($sformatf("FAIL t=%0t: %s got oe=%0b data=%02h, expected oe=%0b data=%02h",
				$time, what, rd_oe, rd_data, exp_oe, want));
	endtask

	task automatic io_write(input logic [7:0] p, input logic [7:0] d);
		run_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, {8'h00, p}, d);
		// port 5 is read only
		if (p[7:3] == 5'h14 && p[2:0] != 3'd5)
			ports[p[2:0]] = d;
	endtask

	task automatic io_read(input logic [7:0] p);
		logic [7:0] exp;
		run_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, {8'h00, p}, 8'h00);
		exp = (p[2:0] == 3'd5) ? fetch_cnt : ports[p[2:0]];
		check_read($sformatf("io read %02h", p), exp, p[7:3] == 5'h14);
	endtask

	task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
		run_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, a, d);
		if (a[15:8] == 8'hC0)
			ram[{ports[7][1:0], a[7:0]}] = d;
	endtask

	task automatic mem_read(input logic [15:0] a);
		run_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, a, 8'h00);
		check_read($sformatf("mem read %04h", a), ram[{ports[7][1:0], a[7:0]}],
			a[15:8] == 8'hC0);
	endtask

	task automatic op_fetch(input logic [15:0] a);
		run_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, a, 8'h00);
		fetch_cnt = fetch_cnt + 8'd1;
		check_read($sformatf("fetch %04h", a), ram[{ports[7][1:0], a[7:0]}], 1'b1);
	endtask

	// refresh with a write level must leave ram alone
	task automatic refresh_write(input logic [15:0] a, input logic [7:0] d);
		run_cycle(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, a, d);
	endtask

	// wr held low too, so a missing m1 mask would hit port 1
	task automatic int_ack(input logic [7:0] d);
		run_cycle(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 16'h00A1, d);
		check_read("int ack vector", ports[6], 1'b1);
	endtask

	always @(negedge clk)
	begin
		if (dut0.decode0.chk0.fail_count != 0)
			fail_now("a bus protocol assertion in the decoder failed");
	end

	initial
	begin
		#(TIMEOUT_NS);
		fail_now("timeout, the bus cycles did not finish in the expected time");
	end

	initial
	begin
		logic [7:0] b;
		logic [7:0] lo [0:3];
		zpos <= 1'b0;
		reset <= 1'b1;
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		m1_n <= 1'b1;
		rfsh_n <= 1'b1;
		rd_n <= 1'b1;
		wr_n <= 1'b1;
		addr <= 16'h0000;
		din <= 8'h00;
		for (int i = 0; i < 8; i++)
			ports[i[2:0]] = 8'h00;
		ports[6] = 8'hFF;
		fetch_cnt = 8'h00;
		rng = 32'd54;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// vector right after reset
		rand_byte(b);
		int_ack(b);

		// plain ports and the vector
		for (int i = 0; i < 7; i++)
		begin
			rand_byte(b);
			if (i != 5)
				io_write({5'h14, i[2:0]}, b);
		end
		for (int i = 0; i < 7; i++)
			if (i != 5)
				io_read({5'h14, i[2:0]});
		io_read(8'hB0);

		// same offsets on two pages
		for (int k = 0; k < 4; k++)
			rand_byte(lo[k]);
		for (int pg = 0; pg < 2; pg++)
		begin
			rand_byte(b);
			io_write(8'hA7, {b[7:2], pg[1:0]});
			for (int k = 0; k < 4; k++)
			begin
				rand_byte(b);
				mem_write({8'hC0, lo[k]}, b);
			end
		end
		for (int pg = 0; pg < 2; pg++)
		begin
			rand_byte(b);
			io_write(8'hA7, {b[7:2], pg[1:0]});
			for (int k = 0; k < 4; k++)
				mem_read({8'hC0, lo[k]});
		end
		io_read(8'hA7);
		mem_read({8'h80, lo[0]});

		// refresh masking
		refresh_write({8'hC0, lo[0]}, ~ram[{ports[7][1:0], lo[0]}]);
		mem_read({8'hC0, lo[0]});

		// fetch counter wraps past 255
		repeat (N_FETCH)
			op_fetch({8'hC0, lo[1]});
		io_read(8'hA5);
		rand_byte(b);
		io_write(8'hA5, b);
		io_read(8'hA5);

		// new vector, then no port may have moved
		rand_byte(b);
		io_write(8'hA6, b);
		rand_byte(b);
		int_ack(b);
		for (int i = 0; i < 8; i++)
			io_read({5'h14, i[2:0]});

		@(negedge clk);
		if (dut0.decode0.chk0.fail_count == 0)
		begin
			$display(">>> PASS");
			$finish;
		end
		else
			fail_now("a bus protocol assertion in the decoder failed");
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/zbus_pkg.sv
common/zbus_if.sv
hdl/zbus_decode.sv
hdl/zport_exec.sv
hdl/zmem_exec.sv
hdl/zdata_result.sv
hdl/zbus_top.sv
verif/zbus_assertions.sv
verif/zbus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the z80 bus slave testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module zbus_tb -f sim.f -o zbus_sim

status=0
./obj_dir/zbus_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log || [ "$status" -ne 0 ] || ! grep -q ">>> PASS" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
